/* flist.f */
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/branch_ctrl.sv
rtl/ex_mem_reg.sv
rtl/execute_unit.sv
tb/ex_checker.sv
tb/tb_execute.sv

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic [rv_isa_pkg::xlen-1:0]   op_a,
    input  wire logic [rv_isa_pkg::xlen-1:0]   op_b,
    input  rv_isa_pkg::alu_op_t                alu_op,
    output logic      [rv_isa_pkg::xlen-1:0]   result
);

    logic [rv_isa_pkg::shamt_w-1:0] shamt;
    logic                           lt_s;
    logic                           lt_u;

    assign shamt = op_b[rv_isa_pkg::shamt_w-1:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    always_comb begin
        case (alu_op)
            rv_isa_pkg::alu_add: begin
                result = op_a + op_b;
            end
            rv_isa_pkg::alu_sub: begin
                result = op_a - op_b;
            end
            rv_isa_pkg::alu_sll: begin
                result = op_a << shamt;
            end
            rv_isa_pkg::alu_slt: begin
                result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_s};
            end
            rv_isa_pkg::alu_sltu: begin
                result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_u};
            end
            rv_isa_pkg::alu_xor: begin
                result = op_a ^ op_b;
            end
            rv_isa_pkg::alu_srl: begin
                result = op_a >> shamt;
            end
            rv_isa_pkg::alu_sra: begin
                result = $unsigned($signed(op_a) >>> shamt);   // Sign fill
            end
            rv_isa_pkg::alu_or: begin
                result = op_a | op_b;
            end
            rv_isa_pkg::alu_and: begin
                result = op_a & op_b;
            end
            default: begin
                result = '0;    // Undefined op codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/branch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_ctrl (
    input  rv_isa_pkg::bj_kind_t               bj_kind,
    input  wire logic [rv_isa_pkg::xlen-1:0]   op_a,
    input  wire logic [rv_isa_pkg::xlen-1:0]   op_b,
    input  wire logic [rv_isa_pkg::xlen-1:0]   reg1,
    input  wire logic [rv_isa_pkg::xlen-1:0]   curr_pc,
    input  wire logic [rv_isa_pkg::xlen-1:0]   imm,
    output logic                               taken,
    output logic      [rv_isa_pkg::xlen-1:0]   target
);

    logic                          eq;
    logic                          lt_s;
    logic                          lt_u;
    logic                          is_jalr;
    logic [rv_isa_pkg::xlen-1:0]   base;
    logic [rv_isa_pkg::xlen-1:0]   offset;

    assign eq   = op_a == op_b;
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // jalr adds imm to the raw rs1, others use the pc and a halfword offset
    assign is_jalr = bj_kind == rv_isa_pkg::bj_jalr;
    assign base    = is_jalr ? reg1 : curr_pc;
    assign offset  = is_jalr ? imm : imm << 1;
    assign target  = base + offset;

    always_comb begin
        case (bj_kind)
            rv_isa_pkg::bj_beq:  taken = eq;
            rv_isa_pkg::bj_bne:  taken = !eq;
            rv_isa_pkg::bj_blt:  taken = lt_s;
            rv_isa_pkg::bj_bge:  taken = !lt_s;
            rv_isa_pkg::bj_bltu: taken = lt_u;
            rv_isa_pkg::bj_bgeu: taken = !lt_u;
            rv_isa_pkg::bj_jal,
            rv_isa_pkg::bj_jalr: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ex_mem_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          stall_mem,
    input  pipe_pkg::ex_mem_t  d,
    output pipe_pkg::ex_mem_t  q
);

    pipe_pkg::ex_mem_t q_r;

    // Zero bundle means no store, no load and no register write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_r <= '0;
        end else if (!stall_mem) begin
            q_r <= d;
        end
    end

    // Held value also feeds the mem forward path
    assign q = q_r;

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  pipe_pkg::id_ex_t                   id_ex,
    input  rv_isa_pkg::fwd_sel_t               fwd_a,
    input  rv_isa_pkg::fwd_sel_t               fwd_b,
    input  wire logic [rv_isa_pkg::xlen-1:0]   wb_data,
    input  wire logic                          stall_mem,
    output pipe_pkg::ex_mem_t                  ex_mem,
    output logic                               branch_taken,
    output logic      [rv_isa_pkg::xlen-1:0]   branch_target
);

    logic [rv_isa_pkg::xlen-1:0]   op_a;
    logic [rv_isa_pkg::xlen-1:0]   op_b;
    logic [rv_isa_pkg::xlen-1:0]   store_data;
    logic [rv_isa_pkg::xlen-1:0]   alu_out;
    logic [rv_isa_pkg::xlen-1:0]   ex_result;
    pipe_pkg::ex_mem_t             ex_mem_d;

    operand_select u_operand_select (
        .reg1       (id_ex.reg1),
        .reg2       (id_ex.reg2),
        .imm        (id_ex.imm),
        .wb_data    (wb_data),
        .mem_result (ex_mem.alu_result),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .data_sel   (id_ex.data_sel),
        .op_a       (op_a),
        .op_b       (op_b),
        .store_data (store_data)
    );

    alu u_alu (
        .op_a   (op_a),
        .op_b   (op_b),
        .alu_op (id_ex.alu_op),
        .result (alu_out)
    );

    branch_ctrl u_branch_ctrl (
        .bj_kind (id_ex.bj_kind),
        .op_a    (op_a),
        .op_b    (op_b),
        .reg1    (id_ex.reg1),
        .curr_pc (id_ex.curr_pc),
        .imm     (id_ex.imm),
        .taken   (branch_taken),
        .target  (branch_target)
    );

    assign ex_result = id_ex.lui ? id_ex.imm : alu_out;   // lui loads the upper immediate

    always_comb begin
        ex_mem_d             = '0;
        ex_mem_d.next_pc     = id_ex.next_pc;
        ex_mem_d.alu_result  = ex_result;
        ex_mem_d.write_data  = store_data;
        ex_mem_d.instruction = id_ex.instruction;
        ex_mem_d.mem_ctrl    = id_ex.mem_ctrl;
        ex_mem_d.wb_ctrl     = id_ex.wb_ctrl;
    end

    ex_mem_reg u_ex_mem_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall_mem (stall_mem),
        .d         (ex_mem_d),
        .q         (ex_mem)
    );

endmodule

`default_nettype wire

/* rtl/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  wire logic [rv_isa_pkg::xlen-1:0]   reg1,
    input  wire logic [rv_isa_pkg::xlen-1:0]   reg2,
    input  wire logic [rv_isa_pkg::xlen-1:0]   imm,
    input  wire logic [rv_isa_pkg::xlen-1:0]   wb_data,
    input  wire logic [rv_isa_pkg::xlen-1:0]   mem_result,
    input  rv_isa_pkg::fwd_sel_t               fwd_a,
    input  rv_isa_pkg::fwd_sel_t               fwd_b,
    input  wire logic                          data_sel,
    output logic      [rv_isa_pkg::xlen-1:0]   op_a,
    output logic      [rv_isa_pkg::xlen-1:0]   op_b,
    output logic      [rv_isa_pkg::xlen-1:0]   store_data
);

    logic [rv_isa_pkg::xlen-1:0] fwd_b_val;

    // Three-way pick, unused select code falls back to the register
    function automatic logic [rv_isa_pkg::xlen-1:0] fwd_mux(
        input rv_isa_pkg::fwd_sel_t          sel,
        input logic [rv_isa_pkg::xlen-1:0]   from_reg,
        input logic [rv_isa_pkg::xlen-1:0]   from_wb,
        input logic [rv_isa_pkg::xlen-1:0]   from_mem
    );
        logic [rv_isa_pkg::xlen-1:0] val;
        case (sel)
            rv_isa_pkg::fwd_wb:  val = from_wb;
            rv_isa_pkg::fwd_mem: val = from_mem;
            default:             val = from_reg;
        endcase
        return val;
    endfunction

    always_comb begin
        op_a      = fwd_mux(fwd_a, reg1, wb_data, mem_result);
        fwd_b_val = fwd_mux(fwd_b, reg2, wb_data, mem_result);
    end

    // Store data skips the immediate choice
    assign store_data = fwd_b_val;
    assign op_b       = data_sel ? imm : fwd_b_val;

endmodule

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // Carried to the memory stage untouched
    typedef struct packed {
        logic                                  mem_wrt_en;
        logic                                  rd_en;
        logic [rv_isa_pkg::read_width_w-1:0]   read_width;
        logic                                  read_unsigned;
        logic                                  random;
        logic                                  rdi;
    } mem_ctrl_t;

    typedef struct packed {
        logic                                  reg_wrt_en;
        logic [rv_isa_pkg::wb_sel_w-1:0]       wb_sel;
        logic [rv_isa_pkg::reg_addr_w-1:0]     wrt_dst;     // Destination register
    } wb_ctrl_t;

    // Decode to execute bundle
    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0]   curr_pc;
        logic [rv_isa_pkg::xlen-1:0]   next_pc;
        logic [rv_isa_pkg::xlen-1:0]   reg1;
        logic [rv_isa_pkg::xlen-1:0]   reg2;
        logic [rv_isa_pkg::xlen-1:0]   imm;
        logic [rv_isa_pkg::xlen-1:0]   instruction;
        rv_isa_pkg::alu_op_t           alu_op;
        rv_isa_pkg::bj_kind_t          bj_kind;
        logic                          data_sel;    // Immediate as B operand
        logic                          lui;
        mem_ctrl_t                     mem_ctrl;
        wb_ctrl_t                      wb_ctrl;
    } id_ex_t;

    // Execute to memory bundle
    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0]   next_pc;
        logic [rv_isa_pkg::xlen-1:0]   alu_result;
        logic [rv_isa_pkg::xlen-1:0]   write_data;  // Store data after forwarding
        logic [rv_isa_pkg::xlen-1:0]   instruction;
        mem_ctrl_t                     mem_ctrl;
        wb_ctrl_t                      wb_ctrl;
    } ex_mem_t;

endpackage

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int xlen         = 32;
    localparam int shamt_w      = 5;    // Shift amount taken from op_b
    localparam int reg_addr_w   = 5;
    localparam int alu_op_w     = 4;
    localparam int bj_kind_w    = 4;
    localparam int fwd_sel_w    = 2;
    localparam int wb_sel_w     = 2;
    localparam int read_width_w = 2;

    // Top bit is funct7[5], low three follow funct3
    typedef enum logic [alu_op_w-1:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    typedef enum logic [bj_kind_w-1:0] {
        bj_none = 4'd0,
        bj_beq  = 4'd1,
        bj_bne  = 4'd2,
        bj_blt  = 4'd3,
        bj_bge  = 4'd4,
        bj_bltu = 4'd5,
        bj_bgeu = 4'd6,
        bj_jal  = 4'd7,
        bj_jalr = 4'd8
    } bj_kind_t;

    // Operand source for the forwarding muxes
    typedef enum logic [fwd_sel_w-1:0] {
        fwd_reg = 2'b00,    // Register file value
        fwd_wb  = 2'b01,    // Write-back data
        fwd_mem = 2'b10     // EX/MEM alu_result
    } fwd_sel_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f flist.f --top-module tb_execute \
    -Mdir obj_dir -o sim_execute

./obj_dir/sim_execute | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "Run passed"
    exit 0
fi

echo "Run failed, see sim.log"
exit 1

/* tb/ex_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          vec_valid,
    input  wire logic [7:0]                    test_num,
    input  wire logic                          exp_taken,
    input  wire logic [rv_isa_pkg::xlen-1:0]   exp_target,
    input  pipe_pkg::ex_mem_t                  exp_ex_mem,
    input  wire logic                          run_end,
    input  pipe_pkg::ex_mem_t                  ex_mem,
    input  wire logic                          branch_taken,
    input  wire logic [rv_isa_pkg::xlen-1:0]   branch_target,
    output int                                 error_count,
    output int                                 tests_passed,
    output int                                 tests_failed,
    output int                                 check_count,
    output logic                               summary_done
);

    logic               reset_checked;
    logic               pend_valid;     // Vector waiting for its ex_mem check
    logic [7:0]         pend_test;
    pipe_pkg::ex_mem_t  pend_ex_mem;
    logic               test_bad [0:255];
    int                 idx;

    function automatic string test_name(input logic [7:0] t);
        case (t)
            8'd0:    return "reset";
            8'd1:    return "alu ops";
            8'd2:    return "forwarding";
            8'd3:    return "branches and jumps";
            8'd4:    return "stall and hold";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare_word(
        input string        field,
        input logic [31:0]  exp,
        input logic [31:0]  act,
        input logic [7:0]   t
    );
        check_count = check_count + 1;
        if (act !== exp) begin
            error_count = error_count + 1;
            test_bad[t] = 1'b1;
            $display("FAIL t=%0t test %0d: %s expected %h, got %h", $time, t, field, exp, act);
        end
    endtask

    task automatic compare_ex_mem(
        input logic [7:0]         t,
        input pipe_pkg::ex_mem_t  exp,
        input pipe_pkg::ex_mem_t  act
    );
        compare_word("ex_mem.next_pc", exp.next_pc, act.next_pc, t);
        compare_word("ex_mem.alu_result", exp.alu_result, act.alu_result, t);
        compare_word("ex_mem.write_data", exp.write_data, act.write_data, t);
        compare_word("ex_mem.instruction", exp.instruction, act.instruction, t);
        compare_word("ex_mem.mem_ctrl", {25'b0, exp.mem_ctrl}, {25'b0, act.mem_ctrl}, t);
        compare_word("ex_mem.wb_ctrl", {24'b0, exp.wb_ctrl}, {24'b0, act.wb_ctrl}, t);
    endtask

    task automatic finish_test(input logic [7:0] t);
        if (test_bad[t]) begin
            tests_failed = tests_failed + 1;
            $display("Test %0d (%s): FAIL", t, test_name(t));
        end else begin
            tests_passed = tests_passed + 1;
            $display("Test %0d (%s): PASS", t, test_name(t));
        end
    endtask

    // Inputs change on the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin
        if (!rst_n) begin
            error_count   = 0;
            tests_passed  = 0;
            tests_failed  = 0;
            check_count   = 0;
            summary_done  = 1'b0;
            reset_checked = 1'b0;
            pend_valid    = 1'b0;
            pend_test     = '0;
            pend_ex_mem   = '0;
            for (idx = 0; idx < 256; idx = idx + 1) begin
                test_bad[idx] = 1'b0;
            end
        end else begin
            if (!reset_checked && !vec_valid) begin
                compare_ex_mem(8'd0, '0, ex_mem);    // Cleared bundle before any vector
                compare_word("branch_taken", 32'd0, {31'b0, branch_taken}, 8'd0);
                finish_test(8'd0);
                reset_checked = 1'b1;
            end
            if (vec_valid) begin
                compare_word("branch_taken", {31'b0, exp_taken}, {31'b0, branch_taken}, test_num);
                compare_word("branch_target", exp_target, branch_target, test_num);
            end
            if (pend_valid) begin
                compare_ex_mem(pend_test, pend_ex_mem, ex_mem);
                if (!vec_valid || test_num != pend_test) begin
                    finish_test(pend_test);
                end
            end
            pend_valid  = vec_valid;
            pend_test   = test_num;
            pend_ex_mem = exp_ex_mem;
            if (run_end && !summary_done) begin
                $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                         tests_passed, tests_failed, check_count, error_count);
                summary_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/ex_stim.txt */
// test ctrl mem wb curr_pc next_pc reg1 reg2 imm instr wb_data, then expected:
// taken target, ex_mem next_pc alu_result write_data instr mem_ctrl wb_ctrl
// ctrl nibbles: alu_op bj_kind data_sel lui fwd_a fwd_b stall; a lone 0 ends the list
1 0000000 0 81 100 104 5 3 0 a1 0 0 100 104 8 3 a1 0 81
1 8000000 0 82 104 108 3 5 0 a2 0 0 104 108 fffffffe 5 a2 0 82
1 0010000 0 83 108 10c 20 77 fffffff0 a3 0 0 e8 10c 10 77 a3 0 83
1 1000000 0 84 10c 110 1 24 0 a4 0 0 10c 110 10 24 a4 0 84
1 2000000 0 85 110 114 ffffffff 1 0 a5 0 0 110 114 1 1 a5 0 85
1 3000000 0 86 114 118 ffffffff 1 0 a6 0 0 114 118 0 1 a6 0 86
1 4000000 0 87 118 11c ff00 ff0 0 a7 0 0 118 11c f0f0 ff0 a7 0 87
1 5000000 0 88 11c 120 80000000 4 0 a8 0 0 11c 120 8000000 4 a8 0 88
1 d000000 0 89 120 124 80000000 4 0 a9 0 0 120 124 f8000000 4 a9 0 89
1 6010000 0 8a 124 128 f0 0 f aa 0 0 142 128 ff 0 aa 0 8a
1 7010000 0 8b 128 12c ff 0 f0f ab 0 0 1f46 12c f 0 ab 0 8b
1 0011000 0 8c 12c 130 5 0 12345000 ac 0 0 2468a12c 130 12345000 0 ac 0 8c
2 0000200 0 8d 130 134 999 1 0 ad 0 0 130 134 12345001 1 ad 0 8d
2 8000120 0 8e 134 138 0 0 0 ae 12345678 0 134 138 677 12345001 ae 0 8e
2 0010010 50 0 138 13c 200 0 8 af cafe 0 148 13c 208 cafe af 50 0
2 0010020 50 0 13c 140 1000 0 4 b0 0 0 144 140 1004 208 b0 50 0
3 0100000 0 0 200 204 7 7 10 b1 0 1 220 204 e 7 b1 0 0
3 0200000 0 0 204 208 7 7 10 b2 0 0 224 208 e 7 b2 0 0
3 0300000 0 0 208 20c fffffffe 1 8 b3 0 1 218 20c ffffffff 1 b3 0 0
3 0400000 0 0 20c 210 fffffffe 1 8 b4 0 0 21c 210 ffffffff 1 b4 0 0
3 0500000 0 0 210 214 fffffffe 1 8 b5 0 0 220 214 ffffffff 1 b5 0 0
3 0600000 0 0 214 218 fffffffe 1 fffffffc b6 0 1 20c 218 ffffffff 1 b6 0 0
3 0100200 0 0 218 21c 0 ffffffff 4 b7 0 1 220 21c fffffffe ffffffff b7 0 0
3 0700000 0 c1 21c 220 0 0 80 b8 0 1 31c 220 0 0 b8 0 c1
3 0810100 0 c1 220 224 300 0 10 b9 5000 1 310 224 5010 0 b9 0 c1
4 0000000 0 83 300 304 40 2 0 c1 0 0 300 304 42 2 c1 0 83
4 0000201 20 84 304 308 0 3 0 c2 0 0 304 304 42 2 c1 0 83
4 0000201 20 84 304 308 0 3 0 c2 0 0 304 304 42 2 c1 0 83
4 0000200 20 84 304 308 0 3 0 c2 0 0 304 308 45 3 c2 20 84
4 0000200 0 85 308 30c 0 5 0 c3 0 0 308 30c 4a 5 c3 0 85
0

/* tb/tb_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_execute;

    localparam int n_cols     = 19;    // Words per vector in the stim file
    localparam int max_vec    = 64;
    localparam int rst_cycles = 4;

    logic                          clk;
    logic                          rst_n;
    pipe_pkg::id_ex_t              id_ex;
    rv_isa_pkg::fwd_sel_t          fwd_a;
    rv_isa_pkg::fwd_sel_t          fwd_b;
    logic [rv_isa_pkg::xlen-1:0]   wb_data;
    logic                          stall_mem;
    pipe_pkg::ex_mem_t             ex_mem;
    logic                          branch_taken;
    logic [rv_isa_pkg::xlen-1:0]   branch_target;

    // Expected values that go with the vector on the DUT inputs
    logic                          vec_valid;
    logic [7:0]                    test_num;
    logic                          exp_taken;
    logic [rv_isa_pkg::xlen-1:0]   exp_target;
    pipe_pkg::ex_mem_t             exp_ex_mem;
    logic                          run_end;

    int                            error_count;
    int                            tests_passed;
    int                            tests_failed;
    int                            check_count;
    logic                          summary_done;

    logic [31:0]                   stim_mem [0:n_cols*max_vec-1];
    int                            n_vec;
    int                            vec_idx;
    int                            cycle_count;
    int                            cycle_limit;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    execute_unit uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .wb_data       (wb_data),
        .stall_mem     (stall_mem),
        .ex_mem        (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    ex_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .vec_valid     (vec_valid),
        .test_num      (test_num),
        .exp_taken     (exp_taken),
        .exp_target    (exp_target),
        .exp_ex_mem    (exp_ex_mem),
        .run_end       (run_end),
        .ex_mem        (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .error_count   (error_count),
        .tests_passed  (tests_passed),
        .tests_failed  (tests_failed),
        .check_count   (check_count),
        .summary_done  (summary_done)
    );

    // List ends at the first test number of zero
    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < max_vec && stim_mem[n*n_cols] != 32'd0) begin
            n = n + 1;
        end
        return n;
    endfunction

    task automatic apply_vector(input int k);
        int                b;
        logic [31:0]       ctrl;
        pipe_pkg::id_ex_t  v;
        pipe_pkg::ex_mem_t e;
        b    = k * n_cols;
        ctrl = stim_mem[b+1];    // One nibble per control field
        v             = '0;
        v.alu_op      = rv_isa_pkg::alu_op_t'(ctrl[27:24]);
        v.bj_kind     = rv_isa_pkg::bj_kind_t'(ctrl[23:20]);
        v.data_sel    = ctrl[16];
        v.lui         = ctrl[12];
        v.mem_ctrl    = stim_mem[b+2][6:0];
        v.wb_ctrl     = stim_mem[b+3][7:0];
        v.curr_pc     = stim_mem[b+4];
        v.next_pc     = stim_mem[b+5];
        v.reg1        = stim_mem[b+6];
        v.reg2        = stim_mem[b+7];
        v.imm         = stim_mem[b+8];
        v.instruction = stim_mem[b+9];
        e.next_pc     = stim_mem[b+13];
        e.alu_result  = stim_mem[b+14];
        e.write_data  = stim_mem[b+15];
        e.instruction = stim_mem[b+16];
        e.mem_ctrl    = stim_mem[b+17][6:0];
        e.wb_ctrl     = stim_mem[b+18][7:0];
        id_ex      <= v;
        fwd_a      <= rv_isa_pkg::fwd_sel_t'(ctrl[9:8]);
        fwd_b      <= rv_isa_pkg::fwd_sel_t'(ctrl[5:4]);
        stall_mem  <= ctrl[0];
        wb_data    <= stim_mem[b+10];
        test_num   <= stim_mem[b][7:0];
        exp_taken  <= stim_mem[b+11][0];
        exp_target <= stim_mem[b+12];
        exp_ex_mem <= e;
        vec_valid  <= 1'b1;
    endtask

    task automatic drive_idle();
        id_ex     <= '0;
        fwd_a     <= rv_isa_pkg::fwd_reg;
        fwd_b     <= rv_isa_pkg::fwd_reg;
        wb_data   <= '0;
        stall_mem <= 1'b0;
        vec_valid <= 1'b0;
        test_num  <= '0;
    endtask

    initial begin
        rst_n      = 1'b0;
        id_ex      = '0;
        fwd_a      = rv_isa_pkg::fwd_wb;    // Nonzero d, only reset keeps ex_mem clear
        fwd_b      = rv_isa_pkg::fwd_wb;
        wb_data    = 32'h5a5a_a5a5;
        stall_mem  = 1'b0;
        vec_valid  = 1'b0;
        test_num   = '0;
        exp_taken  = 1'b0;
        exp_target = '0;
        exp_ex_mem = '0;
        run_end    = 1'b0;
        $readmemh("tb/ex_stim.txt", stim_mem);
        n_vec       = count_vectors();
        cycle_limit = n_vec + rst_cycles + 20;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
        drive_idle();
        for (vec_idx = 0; vec_idx < n_vec; vec_idx = vec_idx + 1) begin
            @(posedge clk);
            apply_vector(vec_idx);
        end
        @(posedge clk);
        drive_idle();    // Last vector gets its ex_mem check here
        @(posedge clk);
        run_end <= 1'b1;
        wait (summary_done === 1'b1);
        if (n_vec > 0 && check_count > 0 && error_count == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Run timed out after %0d cycles before all vectors were checked", cycle_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
